/* source/flowMemPkg.sv */
package flowMemPkg;

   localparam int DATA_W = 32;
   localparam int ADDR_W = 8;
   localparam int PERIOD_W = 6;
   localparam int FLOW_N = 4;
   localparam int SEL_W = 2;

   typedef logic [DATA_W-1:0] dataT;
   typedef logic [ADDR_W-1:0] addrT;
   typedef logic [PERIOD_W-1:0] periodT;
   typedef logic [SEL_W-1:0] flowSelT;

   // input flow bus, word 0 in the low bits
   typedef struct packed {
      dataT [FLOW_N-1:0] words;
   } flowBusT;

   // outA sits in the high half
   typedef struct packed {
      dataT outA;
      dataT outB;
   } flowPairT;

   // one RAM port program
   typedef struct packed {
      addrT    iterations;
      periodT  period;
      periodT  duty;
      flowSelT sel;
      addrT    start;
      addrT    shift;
      addrT    incr;
      periodT  delay;
      logic    reverse;
      logic    inWrite;
      logic    addrOutEn;
   } portConfigT;

   // field select for the configuration bank
   typedef enum logic [3:0] {
      CFG_ITER     = 4'd0,
      CFG_PERIOD   = 4'd1,
      CFG_DUTY     = 4'd2,
      CFG_SEL      = 4'd3,
      CFG_START    = 4'd4,
      CFG_SHIFT    = 4'd5,
      CFG_INCR     = 4'd6,
      CFG_DELAY    = 4'd7,
      CFG_REVERSE  = 4'd8,
      CFG_IN_WRITE = 4'd9,
      CFG_ADDR_OUT = 4'd10
   } cfgFieldT;

endpackage

/* source/addressGenerator.sv */
module addressGenerator (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   init,
   input  logic                   run,
   input  flowMemPkg::portConfigT portConfig,
   output flowMemPkg::addrT       addr,
   output logic                   memEn,
   output logic                   done
);

   import flowMemPkg::*;

   typedef enum logic [1:0] {
      IDLE,
      DELAYING,
      RUNNING,
      FINISHED
   } genStateT;

   genStateT state;
   periodT   delayCnt;
   periodT   perCnt;
   addrT     iterCnt;
   // start + iter * shift
   addrT     iterBase;
   // iterBase + step * incr
   addrT     addrReg;
   logic     periodEnd;
   logic     lastIter;

   assign periodEnd = (perCnt == portConfig.period - 1'b1);
   assign lastIter = (iterCnt == portConfig.iterations - 1'b1);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state    <= IDLE;
         delayCnt <= '0;
         perCnt   <= '0;
         iterCnt  <= '0;
         iterBase <= '0;
         addrReg  <= '0;
      end
      else if (init)
      begin
         state <= IDLE;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               // zero iterations means no program
               if (run && (portConfig.iterations != '0))
               begin
                  state    <= (portConfig.delay != '0) ? DELAYING : RUNNING;
                  delayCnt <= portConfig.delay;
                  perCnt   <= '0;
                  iterCnt  <= '0;
                  iterBase <= portConfig.start;
                  addrReg  <= portConfig.start;
               end
            end
            DELAYING:
            begin
               delayCnt <= delayCnt - 1'b1;
               if (delayCnt == periodT'(1))
               begin
                  state <= RUNNING;
               end
            end
            RUNNING:
            begin
               if (periodEnd)
               begin
                  perCnt <= '0;
                  if (lastIter)
                  begin
                     state <= FINISHED;
                  end
                  else
                  begin
                     // next outer iteration restarts from the shifted base
                     iterCnt  <= iterCnt + 1'b1;
                     iterBase <= iterBase + portConfig.shift;
                     addrReg  <= iterBase + portConfig.shift;
                  end
               end
               else
               begin
                  perCnt  <= perCnt + 1'b1;
                  addrReg <= addrReg + portConfig.incr;
               end
            end
            default:
            begin
               // finished holds until init
               state <= state;
            end
         endcase
      end
   end

   assign addr = addrReg;
   assign memEn = (state == RUNNING) && (perCnt < portConfig.duty);
   assign done = (state == FINISHED);

   // program must hold still while a run is in progress
   assert property (@(posedge clk) disable iff (rst || init)
      ((state == DELAYING) || (state == RUNNING)) |-> $stable(portConfig));

   assert property (@(posedge clk) disable iff (rst) !(memEn && done));

endmodule

/* source/dualPortRam.sv */
module dualPortRam (
   input  logic             clk,
   input  logic             enA,
   input  logic             weA,
   input  flowMemPkg::addrT addrA,
   input  flowMemPkg::dataT dataInA,
   input  logic             enB,
   input  logic             weB,
   input  flowMemPkg::addrT addrB,
   input  flowMemPkg::dataT dataInB,
   output flowMemPkg::dataT qA,
   output flowMemPkg::dataT qB
);

   import flowMemPkg::*;

   dataT mem [0:(2**ADDR_W)-1];

   always_ff @(posedge clk)
   begin
      if (enA && weA)
      begin
         mem[addrA] <= dataInA;
      end
      if (enB && weB)
      begin
         mem[addrB] <= dataInB;
      end
   end

   // read-first and q holds between accesses
   always_ff @(posedge clk)
   begin
      if (enA)
      begin
         qA <= mem[addrA];
      end
      if (enB)
      begin
         qB <= mem[addrB];
      end
   end

   assert property (@(posedge clk)
      !(enA && weA && enB && weB && (addrA == addrB)));

endmodule

/* source/memoryUnit.sv */
module memoryUnit (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   initA,
   input  logic                   initB,
   input  logic                   runA,
   input  logic                   runB,
   input  logic                   hostReq,
   input  logic                   hostWe,
   input  flowMemPkg::addrT       hostAddr,
   input  flowMemPkg::dataT       hostData,
   input  flowMemPkg::flowBusT    flowIn,
   input  flowMemPkg::portConfigT configA,
   input  flowMemPkg::portConfigT configB,
   output logic                   doneA,
   output logic                   doneB,
   output flowMemPkg::flowPairT   flowOut
);

   import flowMemPkg::*;

   addrT genAddrA;
   addrT genAddrB;
   addrT portAddrA;
   addrT portAddrB;
   addrT ramAddrA;
   logic genEnA;
   logic genEnB;
   logic ramEnA;
   logic ramWeA;
   logic ramWeB;
   dataT inA;
   dataT inB;
   dataT ramDataA;
   dataT qA;
   dataT qB;

   function automatic addrT reverseBits(input addrT word);
      addrT result;
      for (int i = 0; i < ADDR_W; i++)
      begin
         result[i] = word[ADDR_W-1-i];
      end
      return result;
   endfunction

   function automatic dataT signExtend(input addrT word);
      return {{(DATA_W-ADDR_W){word[ADDR_W-1]}}, word};
   endfunction

   addressGenerator genA (
      .clk       (clk),
      .rst       (rst),
      .init      (initA),
      .run       (runA),
      .portConfig(configA),
      .addr      (genAddrA),
      .memEn     (genEnA),
      .done      (doneA)
   );

   addressGenerator genB (
      .clk       (clk),
      .rst       (rst),
      .init      (initB),
      .run       (runB),
      .portConfig(configB),
      .addr      (genAddrB),
      .memEn     (genEnB),
      .done      (doneB)
   );

   // flow word per port
   assign inA = flowIn.words[configA.sel];
   assign inB = flowIn.words[configB.sel];

   assign portAddrA = configA.reverse ? reverseBits(genAddrA) : genAddrA;
   assign portAddrB = configB.reverse ? reverseBits(genAddrB) : genAddrB;

   // host steals port A and drops the generator step
   assign ramEnA = hostReq | genEnA;
   assign ramWeA = hostReq ? hostWe : (genEnA & configA.inWrite);
   assign ramAddrA = hostReq ? hostAddr : portAddrA;
   assign ramDataA = hostReq ? hostData : inA;

   assign ramWeB = genEnB & configB.inWrite;

   dualPortRam ram (
      .clk    (clk),
      .enA    (ramEnA),
      .weA    (ramWeA),
      .addrA  (ramAddrA),
      .dataInA(ramDataA),
      .enB    (genEnB),
      .weB    (ramWeB),
      .addrB  (portAddrB),
      .dataInB(inB),
      .qA     (qA),
      .qB     (qB)
   );

   assign flowOut.outA = configA.addrOutEn ? signExtend(portAddrA) : qA;
   assign flowOut.outB = configB.addrOutEn ? signExtend(portAddrB) : qB;

   // a host write never lands on the address port B is writing
   assert property (@(posedge clk) disable iff (rst)
      (hostReq && hostWe && ramWeB) |-> (hostAddr != portAddrB));

endmodule

/* source/configBank.sv */
module configBank (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   cfgWrite,
   input  logic                   cfgPort,
   input  flowMemPkg::cfgFieldT   cfgField,
   input  flowMemPkg::dataT       cfgData,
   output flowMemPkg::portConfigT configA,
   output flowMemPkg::portConfigT configB
);

   import flowMemPkg::*;

   // low bits of value go into the addressed field
   function automatic portConfigT writeField(input portConfigT current,
                                             input cfgFieldT field,
                                             input dataT value);
      portConfigT next;
      next = current;
      case (field)
         CFG_ITER:     next.iterations = value[ADDR_W-1:0];
         CFG_PERIOD:   next.period = value[PERIOD_W-1:0];
         CFG_DUTY:     next.duty = value[PERIOD_W-1:0];
         CFG_SEL:      next.sel = value[SEL_W-1:0];
         CFG_START:    next.start = value[ADDR_W-1:0];
         CFG_SHIFT:    next.shift = value[ADDR_W-1:0];
         CFG_INCR:     next.incr = value[ADDR_W-1:0];
         CFG_DELAY:    next.delay = value[PERIOD_W-1:0];
         CFG_REVERSE:  next.reverse = value[0];
         CFG_IN_WRITE: next.inWrite = value[0];
         CFG_ADDR_OUT: next.addrOutEn = value[0];
         default:      next = current;
      endcase
      return next;
   endfunction

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         configA <= '0;
         configB <= '0;
      end
      else if (cfgWrite)
      begin
         if (cfgPort)
         begin
            configB <= writeField(configB, cfgField, cfgData);
         end
         else
         begin
            configA <= writeField(configA, cfgField, cfgData);
         end
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      cfgWrite |-> (!$isunknown(cfgField) && (cfgField inside {[CFG_ITER:CFG_ADDR_OUT]})));

endmodule

/* source/flowMemTop.sv */
module flowMemTop (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cfgWrite,
   input  logic                 cfgPort,
   input  flowMemPkg::cfgFieldT cfgField,
   input  flowMemPkg::dataT     cfgData,
   input  logic                 initA,
   input  logic                 initB,
   input  logic                 runA,
   input  logic                 runB,
   input  logic                 hostReq,
   input  logic                 hostWe,
   input  flowMemPkg::addrT     hostAddr,
   input  flowMemPkg::dataT     hostData,
   input  flowMemPkg::flowBusT  flowIn,
   output logic                 doneA,
   output logic                 doneB,
   output flowMemPkg::flowPairT flowOut
);

   import flowMemPkg::*;

   portConfigT configA;
   portConfigT configB;

   configBank bank (
      .clk     (clk),
      .rst     (rst),
      .cfgWrite(cfgWrite),
      .cfgPort (cfgPort),
      .cfgField(cfgField),
      .cfgData (cfgData),
      .configA (configA),
      .configB (configB)
   );

   memoryUnit mem (
      .clk     (clk),
      .rst     (rst),
      .initA   (initA),
      .initB   (initB),
      .runA    (runA),
      .runB    (runB),
      .hostReq (hostReq),
      .hostWe  (hostWe),
      .hostAddr(hostAddr),
      .hostData(hostData),
      .flowIn  (flowIn),
      .configA (configA),
      .configB (configB),
      .doneA   (doneA),
      .doneB   (doneB),
      .flowOut (flowOut)
   );

endmodule

/* verif/flowMemTb.sv */
module flowMemTb;

   timeunit 1ns;
   timeprecision 1ps;

   import flowMemPkg::*;

   logic       clk;
   logic       rst;
   logic       cfgWrite;
   logic       cfgPort;
   cfgFieldT   cfgField;
   dataT       cfgData;
   logic       initA;
   logic       initB;
   logic       runA;
   logic       runB;
   logic       hostReq;
   logic       hostWe;
   addrT       hostAddr;
   dataT       hostData;
   flowBusT    flowIn;
   logic       doneA;
   logic       doneB;
   flowPairT   flowOut;

   // testbench view of RAM contents and port programs
   dataT       modelMem [0:255];
   portConfigT shadow [0:1];

   flowMemTop uut (
      .clk     (clk),
      .rst     (rst),
      .cfgWrite(cfgWrite),
      .cfgPort (cfgPort),
      .cfgField(cfgField),
      .cfgData (cfgData),
      .initA   (initA),
      .initB   (initB),
      .runA    (runA),
      .runB    (runB),
      .hostReq (hostReq),
      .hostWe  (hostWe),
      .hostAddr(hostAddr),
      .hostData(hostData),
      .flowIn  (flowIn),
      .doneA   (doneA),
      .doneB   (doneB),
      .flowOut (flowOut)
   );

   always #4 clk = ~clk;

   task automatic stopOnError(input string msg);
      $display("[FAIL] %0d ns: %s", $time, msg);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkData(input dataT got, input dataT exp, input string what);
      if (got !== exp)
      begin
         stopOnError($sformatf("%s got %08h expected %08h", what, got, exp));
      end
   endtask

   task automatic checkDone(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         stopOnError($sformatf("%s done got %b expected %b", what, got, exp));
      end
   endtask

   // address of step s by the loop rule, bit reversed when set
   function automatic addrT seqAddr(input portConfigT c, input int s);
      int   it;
      int   k;
      addrT a;
      addrT r;
      it = s / c.period;
      k = s % c.period;
      a = addrT'(c.start + it * c.shift + k * c.incr);
      for (int i = 0; i < 8; i++)
      begin
         r[i] = a[7-i];
      end
      return c.reverse ? r : a;
   endfunction

   function automatic bit stepOn(input portConfigT c, input int s);
      return (s % c.period) < c.duty;
   endfunction

   task automatic setField(input int p, input int f, input dataT v);
      @(negedge clk);
      cfgWrite = 1'b1;
      cfgPort = p[0];
      cfgField = cfgFieldT'(f);
      cfgData = v;
      case (f)
         0: shadow[p].iterations = v[7:0];
         1: shadow[p].period = v[5:0];
         2: shadow[p].duty = v[5:0];
         3: shadow[p].sel = v[1:0];
         4: shadow[p].start = v[7:0];
         5: shadow[p].shift = v[7:0];
         6: shadow[p].incr = v[7:0];
         7: shadow[p].delay = v[5:0];
         8: shadow[p].reverse = v[0];
         9: shadow[p].inWrite = v[0];
         default: shadow[p].addrOutEn = v[0];
      endcase
      @(negedge clk);
      cfgWrite = 1'b0;
   endtask

   task automatic hostWrite(input addrT a, input dataT v);
      @(negedge clk);
      hostReq = 1'b1;
      hostWe = 1'b1;
      hostAddr = a;
      hostData = v;
      modelMem[a] = v;
      @(negedge clk);
      hostReq = 1'b0;
      hostWe = 1'b0;
   endtask

   task automatic hostRead(input addrT a, input dataT exp);
      @(negedge clk);
      hostReq = 1'b1;
      hostWe = 1'b0;
      hostAddr = a;
      @(negedge clk);
      hostReq = 1'b0;
      checkData(flowOut.outA, exp, $sformatf("host read %02h", a));
   endtask

   task automatic pulseInit(input int p);
      @(negedge clk);
      initA = (p == 0);
      initB = (p == 1);
      @(negedge clk);
      initA = 1'b0;
      initB = 1'b0;
   endtask

   task automatic startRun(input int p, input bit busy);
      @(negedge clk);
      runA = (p == 0);
      runB = (p == 1);
      hostReq = busy;
      hostWe = 1'b0;
      hostAddr = 8'h10;
      @(negedge clk);
      runA = 1'b0;
      runB = 1'b0;
   endtask

   // steps the run cycle by cycle while checking outputs and predicting writes
   task automatic runPort(input int p, input bit busy);
      portConfigT c;
      int         cyc;
      int         d;
      int         total;
      int         s;
      addrT       a;
      dataT       outp;
      c = shadow[p];
      d = c.delay;
      total = c.iterations * c.period;
      cyc = 0;
      startRun(p, busy);
      while ((cyc <= d + total) && (cyc < 2000))
      begin
         flowIn = {$urandom, $urandom, $urandom, $urandom};
         outp = p ? flowOut.outB : flowOut.outA;
         s = cyc - d;
         if ((s >= 1) && (s <= total) && stepOn(c, s - 1) && !c.inWrite && !c.addrOutEn)
         begin
            checkData(outp, modelMem[seqAddr(c, s - 1)], $sformatf("read step %0d", s - 1));
         end
         if ((s >= 0) && (s < total) && stepOn(c, s))
         begin
            a = seqAddr(c, s);
            if (c.addrOutEn)
            begin
               checkData(outp, {{24{a[7]}}, a}, $sformatf("address out step %0d", s));
            end
            if (c.inWrite)
            begin
               modelMem[a] = flowIn.words[c.sel];
            end
         end
         checkDone(p ? doneB : doneA, logic'(cyc >= d + total), "run");
         cyc++;
         @(negedge clk);
      end
      hostReq = 1'b0;
      if (cyc >= 2000)
      begin
         $display("timeout: port %0d run did not finish", p);
         $display("CHECKS FAILED");
         $fatal(1, "run timed out");
      end
   endtask

   task automatic zeroRun(input int p);
      startRun(p, 1'b0);
      for (int i = 0; i < 2000; i++)
      begin
         checkDone(p ? doneB : doneA, 1'b0, "zero-iteration run");
         @(negedge clk);
      end
   endtask

   initial
   begin
      int    fd;
      int    cnt;
      string line;
      byte   cmd;
      dataT  a;
      dataT  b;
      dataT  c;
      clk = 1'b0;
      rst = 1'b1;
      cfgWrite = 1'b0;
      cfgPort = 1'b0;
      cfgField = CFG_ITER;
      cfgData = '0;
      initA = 1'b0;
      initB = 1'b0;
      runA = 1'b0;
      runB = 1'b0;
      hostReq = 1'b0;
      hostWe = 1'b0;
      hostAddr = '0;
      hostData = '0;
      shadow[0] = '0;
      shadow[1] = '0;
      void'($urandom(32'h531e2204));
      flowIn = {$urandom, $urandom, $urandom, $urandom};
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      fd = $fopen("verif/flowMem_testdata.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the test data file");
         $display("CHECKS FAILED");
         $fatal(1, "no test data");
      end
      while (!$feof(fd))
      begin
         cnt = $fgets(line, fd);
         if ((cnt > 1) && (line[0] != "#"))
         begin
            cnt = $sscanf(line, "%c %h %h %h", cmd, a, b, c);
            case (cmd)
               "W": hostWrite(a[7:0], b);
               "V": hostRead(a[7:0], b);
               "R": hostRead(a[7:0], modelMem[a[7:0]]);
               "C": setField(int'(a), int'(b), c);
               "I": pulseInit(int'(a));
               "G": runPort(int'(a), b[0]);
               "Z": zeroRun(int'(a));
               "X": checkData(a[0] ? flowOut.outB : flowOut.outA, b, "captured output");
               "D": checkDone(a[0] ? doneB : doneA, b[0], "level");
               default: $display("skipping unknown command %c", cmd);
            endcase
         end
      end
      $fclose(fd);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* verif/flowMem_testdata.txt */
# cmd a b c (hex)  W addr data | V addr exp | R addr (model) | C port field value
# I port | G port hostBusy | Z port | X port exp | D port doneLevel
D 0 0
D 1 0
W 10 cafe0001
V 10 cafe0001
W 11 12345678
V 11 12345678
W 42 aaaa0042
W 4a aaaa004a
C 1 0 3
C 1 1 4
C 1 2 2
C 1 3 2
C 1 4 40
C 1 5 8
C 1 6 1
C 1 7 2
C 1 9 1
G 1 1
D 1 1
R 40
R 41
R 42
R 48
R 49
R 4a
R 50
R 51
I 1
D 1 0
C 0 0 2
C 0 1 3
C 0 2 3
C 0 4 40
C 0 5 8
C 0 6 1
G 0 0
D 0 1
X 0 aaaa004a
W 01 11111111
C 1 0 2
C 1 1 2
C 1 3 1
C 1 4 1
C 1 5 2
C 1 7 0
C 1 8 1
G 1 0
R 80
R 40
R c0
R 20
R 01
I 0
C 0 a 1
C 0 4 f0
G 0 0
X 0 fffffffa
C 0 a 0
I 1
C 1 0 0
Z 1
D 1 0

/* filelist.f */
source/flowMemPkg.sv
source/addressGenerator.sv
source/dualPortRam.sv
source/memoryUnit.sv
source/configBank.sv
source/flowMemTop.sv
verif/flowMemTb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module flowMemTb \
		-f filelist.f -Mdir obj_dir -o flowMemSim

run: compile
	./obj_dir/flowMemSim | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
